/* pe_pkg.sv */
package pe_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // operation codes
  ////////////////////////////////////////////////////////////////////////////

  // bit 1 picks the multiplier and bit 0 picks subtract for the adder
  typedef enum logic [1:0] {
    op_add     = 2'd0,  // inp1 + inp2
    op_sub     = 2'd1,  // inp1 - inp2
    op_mul     = 2'd2,  // inp1 * inp2
    op_mul_alt = 2'd3   // also a multiply since bit 1 is set
  } pe_op_e;

  ////////////////////////////////////////////////////////////////////////////
  // binary64 field widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int exp_w_dbl = 11;  // exponent field
  localparam int man_w_dbl = 52;  // stored mantissa, hidden bit not counted

  // the word is sign + exponent + mantissa, 64 bits for the defaults above.
  // exponent bias follows the usual IEEE rule of all ones in exp_w - 1 bits,
  // i.e. 1023 for binary64 and 127 for binary32.
  // each stage derives it locally from its own exp_w

  ////////////////////////////////////////////////////////////////////////////
  // pipeline timing
  ////////////////////////////////////////////////////////////////////////////

  // unpack, arith and normalize each add one register stage
  localparam int pipe_depth = 3;

endpackage

/* fp_stage_if.sv */
`timescale 1ns/1ps

// unpacked operands from stage 1 into stage 2
interface fp_operand_if #(
  parameter int exp_w = pe_pkg::exp_w_dbl,
  parameter int man_w = pe_pkg::man_w_dbl
);

  logic             a_sign;
  logic [exp_w-1:0] a_exp;   // still biased
  logic [man_w:0]   a_man;   // hidden bit on top
  logic             a_zero;  // exp field was zero, denormals too
  logic             b_sign;
  logic [exp_w-1:0] b_exp;
  logic [man_w:0]   b_man;
  logic             b_zero;
  pe_pkg::pe_op_e   op;

  modport src (output a_sign, a_exp, a_man, a_zero, b_sign, b_exp, b_man, b_zero, op);
  modport dst (input  a_sign, a_exp, a_man, a_zero, b_sign, b_exp, b_man, b_zero, op);

endinterface

// raw arithmetic result from stage 2 into stage 3
interface fp_result_if #(
  parameter int exp_w = pe_pkg::exp_w_dbl,
  parameter int man_w = pe_pkg::man_w_dbl
);

  logic                       res_sign;
  logic signed [exp_w:0]      res_exp;   // biased, may go negative or past max
  logic [2*(man_w+1)-1:0]     res_man;   // binary point below bit 2*man_w
  logic                       res_zero;

  modport src (output res_sign, res_exp, res_man, res_zero);
  modport dst (input  res_sign, res_exp, res_man, res_zero);

endinterface

/* fp_unpack.sv */
`timescale 1ns/1ps

// stage 1: split both operands into fields and register them
module fp_unpack #(
  parameter int exp_w = pe_pkg::exp_w_dbl,
  parameter int man_w = pe_pkg::man_w_dbl
) (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic [exp_w+man_w:0]   inp1,
  input  logic [exp_w+man_w:0]   inp2,
  input  pe_pkg::pe_op_e         op,
  fp_operand_if.src              stage
);

  localparam int dw = 1 + exp_w + man_w;

  logic [exp_w-1:0] a_exp_f;  // raw exponent fields
  logic [exp_w-1:0] b_exp_f;
  logic             a_nz;     // exponent field nonzero
  logic             b_nz;

  assign a_exp_f = inp1[man_w +: exp_w];
  assign b_exp_f = inp2[man_w +: exp_w];
  assign a_nz    = |a_exp_f;
  assign b_nz    = |b_exp_f;

  ////////////////////////////////////////////////////////////////////////////
  // operand register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      stage.a_sign <= 1'b0;
      stage.a_exp  <= '0;
      stage.a_man  <= '0;
      stage.a_zero <= 1'b0;
      stage.b_sign <= 1'b0;
      stage.b_exp  <= '0;
      stage.b_man  <= '0;
      stage.b_zero <= 1'b0;
      stage.op     <= pe_pkg::op_add;
    end else begin
      stage.a_sign <= inp1[dw-1];
      stage.a_exp  <= a_exp_f;
      stage.a_man  <= {a_nz, inp1[man_w-1:0]};  // hidden one unless zero/denormal
      stage.a_zero <= ~a_nz;                    // denormals read as zero
      stage.b_sign <= inp2[dw-1];
      stage.b_exp  <= b_exp_f;
      stage.b_man  <= {b_nz, inp2[man_w-1:0]};
      stage.b_zero <= ~b_nz;
      stage.op     <= op;
    end
  end

endmodule

/* fp_arith.sv */
`timescale 1ns/1ps

// stage 2: mantissa add/sub or multiply, result left unnormalized
module fp_arith #(
  parameter int exp_w = pe_pkg::exp_w_dbl,
  parameter int man_w = pe_pkg::man_w_dbl
) (
  input  logic       clk,
  input  logic       arst_n,
  fp_operand_if.dst  opnd,
  fp_result_if.src   res
);

  localparam int mw  = man_w + 1;   // mantissa incl hidden bit
  localparam int mw2 = 2 * mw;      // product width
  localparam int ew  = exp_w + 2;   // room for exponent sums
  localparam logic signed [ew-1:0] bias    = ew'((1 << (exp_w - 1)) - 1);
  localparam logic signed [ew-1:0] exp_cap = ew'((1 << exp_w) - 1);  // top of res_exp

  logic                    is_mul;
  logic                    b_sign_eff;  // b sign after subtract flip
  logic signed [ew-1:0]    mul_exp;
  logic [mw2-1:0]          mul_man;
  logic                    a_bigger;
  logic                    big_sign;
  logic                    small_sign;
  logic [exp_w-1:0]        big_exp;
  logic [exp_w-1:0]        exp_diff;
  logic [mw2-1:0]          big_ext;
  logic [mw2-1:0]          small_ext;
  logic [mw2-1:0]          sum_man;
  logic                    cancel;
  logic                    nxt_sign;
  logic signed [exp_w:0]   nxt_exp;
  logic [mw2-1:0]          nxt_man;
  logic                    nxt_zero;

  assign is_mul     = (opnd.op == pe_pkg::op_mul) || (opnd.op == pe_pkg::op_mul_alt);
  assign b_sign_eff = opnd.b_sign ^ (opnd.op == pe_pkg::op_sub);

  ////////////////////////////////////////////////////////////////////////////
  // multiply path
  ////////////////////////////////////////////////////////////////////////////

  assign mul_man = {{mw{1'b0}}, opnd.a_man} * {{mw{1'b0}}, opnd.b_man};  // full product
  assign mul_exp = $signed(ew'(opnd.a_exp)) + $signed(ew'(opnd.b_exp)) - bias;

  ////////////////////////////////////////////////////////////////////////////
  // add / subtract path
  ////////////////////////////////////////////////////////////////////////////

  // magnitude compare on exponent then mantissa
  assign a_bigger   = {opnd.a_exp, opnd.a_man} >= {opnd.b_exp, opnd.b_man};
  assign big_sign   = a_bigger ? opnd.a_sign : b_sign_eff;
  assign small_sign = a_bigger ? b_sign_eff : opnd.a_sign;
  assign big_exp    = a_bigger ? opnd.a_exp : opnd.b_exp;
  assign exp_diff   = a_bigger ? (opnd.a_exp - opnd.b_exp) : (opnd.b_exp - opnd.a_exp);

  // point moved to bit 2*man_w to line up with the product
  assign big_ext   = {1'b0, (a_bigger ? opnd.a_man : opnd.b_man), {man_w{1'b0}}};
  assign small_ext = {1'b0, (a_bigger ? opnd.b_man : opnd.a_man), {man_w{1'b0}}} >> exp_diff;

  assign sum_man = (big_sign == small_sign) ? (big_ext + small_ext)
                                            : (big_ext - small_ext);  // big >= small
  assign cancel  = (sum_man == '0);

  ////////////////////////////////////////////////////////////////////////////
  // result select incl zero operands
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    nxt_sign = 1'b0;
    nxt_exp  = '0;
    nxt_man  = '0;
    nxt_zero = 1'b1;
    if (is_mul) begin
      nxt_sign = opnd.a_sign ^ opnd.b_sign;  // also the sign of a zero product
      if (!(opnd.a_zero || opnd.b_zero)) begin
        nxt_zero = 1'b0;
        nxt_exp  = (mul_exp > exp_cap) ? exp_cap[exp_w:0] : mul_exp[exp_w:0];  // clamp high
        nxt_man  = mul_man;
      end
    end else if (opnd.a_zero && opnd.b_zero) begin
      nxt_sign = opnd.a_sign & b_sign_eff;  // -0 only from -0 + -0
    end else if (opnd.a_zero) begin
      nxt_sign = b_sign_eff;                // pass b through
      nxt_zero = 1'b0;
      nxt_exp  = {1'b0, opnd.b_exp};
      nxt_man  = {1'b0, opnd.b_man, {man_w{1'b0}}};
    end else if (opnd.b_zero) begin
      nxt_sign = opnd.a_sign;               // pass a through
      nxt_zero = 1'b0;
      nxt_exp  = {1'b0, opnd.a_exp};
      nxt_man  = {1'b0, opnd.a_man, {man_w{1'b0}}};
    end else begin
      nxt_sign = cancel ? 1'b0 : big_sign;  // exact cancel gives +0
      nxt_zero = cancel;
      nxt_exp  = {1'b0, big_exp};
      nxt_man  = sum_man;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      res.res_sign <= 1'b0;
      res.res_exp  <= '0;
      res.res_man  <= '0;
      res.res_zero <= 1'b0;
    end else begin
      res.res_sign <= nxt_sign;
      res.res_exp  <= nxt_exp;
      res.res_man  <= nxt_man;
      res.res_zero <= nxt_zero;
    end
  end

endmodule

/* fp_normalize.sv */
`timescale 1ns/1ps

// stage 3: leading one search, exponent fixup and packing
module fp_normalize #(
  parameter int exp_w = pe_pkg::exp_w_dbl,
  parameter int man_w = pe_pkg::man_w_dbl
) (
  input  logic                  clk,
  input  logic                  arst_n,
  fp_result_if.dst              res,
  output logic [exp_w+man_w:0]  out1
);

  localparam int mw2 = 2 * (man_w + 1);
  localparam int ew  = exp_w + 3;  // res_exp plus shift range
  localparam logic signed [ew-1:0] point_pos = ew'(2 * man_w);         // hidden bit of product
  localparam logic signed [ew-1:0] exp_max   = ew'((1 << exp_w) - 1);  // all ones = inf

  logic signed [ew-1:0]    lead_pos;  // index of leading one
  logic signed [ew-1:0]    exp_n;     // exponent after normalizing
  logic [mw2-1:0]          norm_man;  // leading one at the top bit
  logic [exp_w+man_w:0]    pack_w;

  // highest set bit wins
  always_comb begin
    lead_pos = '0;
    for (int i = 0; i < mw2; i++) begin
      if (res.res_man[i]) lead_pos = ew'(i);
    end
  end

  assign norm_man = res.res_man << (mw2 - 1 - lead_pos);
  assign exp_n    = $signed({{2{res.res_exp[exp_w]}}, res.res_exp}) + lead_pos - point_pos;

  ////////////////////////////////////////////////////////////////////////////
  // special cases and packing
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    if (res.res_zero || (res.res_man == '0)) begin
      pack_w = {res.res_sign, {(exp_w + man_w){1'b0}}};           // signed zero
    end else if (exp_n >= exp_max) begin
      pack_w = {res.res_sign, {exp_w{1'b1}}, {man_w{1'b0}}};      // saturate to inf
    end else if (exp_n[ew-1] || (exp_n == '0)) begin
      pack_w = {res.res_sign, {(exp_w + man_w){1'b0}}};           // flush, no denormals
    end else begin
      // hidden bit dropped, lower bits truncated
      pack_w = {res.res_sign, exp_n[exp_w-1:0], norm_man[mw2-2 -: man_w]};
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out1 <= '0;
    end else begin
      out1 <= pack_w;
    end
  end

endmodule

/* pe_typec.sv */
`timescale 1ns/1ps

// double precision PE, add/sub/mul with three cycle latency
module pe_typec #(
  parameter int exp_w = pe_pkg::exp_w_dbl,
  parameter int man_w = pe_pkg::man_w_dbl
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic [exp_w+man_w:0]  inp1,
  input  logic [exp_w+man_w:0]  inp2,
  input  logic [1:0]            op,    // bit 1 mul, bit 0 sub
  output logic [exp_w+man_w:0]  out1
);

  // stage links
  fp_operand_if #(.exp_w(exp_w), .man_w(man_w)) u_opnd_if ();
  fp_result_if  #(.exp_w(exp_w), .man_w(man_w)) u_res_if ();

  fp_unpack #(.exp_w(exp_w), .man_w(man_w)) u_unpack (
    .clk    (clk),
    .arst_n (arst_n),
    .inp1   (inp1),
    .inp2   (inp2),
    .op     (pe_pkg::pe_op_e'(op)),
    .stage  (u_opnd_if.src)
  );

  fp_arith #(.exp_w(exp_w), .man_w(man_w)) u_arith (
    .clk    (clk),
    .arst_n (arst_n),
    .opnd   (u_opnd_if.dst),
    .res    (u_res_if.src)
  );

  fp_normalize #(.exp_w(exp_w), .man_w(man_w)) u_normalize (
    .clk    (clk),
    .arst_n (arst_n),
    .res    (u_res_if.dst),
    .out1   (out1)
  );

endmodule

/* pe_checker.sv */
`timescale 1ns/1ps

// watches the DUT ports, predicts every result and compares it on out1
module pe_checker (
  input  logic        clk,
  input  logic        arst_n,
  input  logic [63:0] inp1,
  input  logic [63:0] inp2,
  input  logic [1:0]  op,
  input  logic [63:0] out1,
  output int          num_checks,
  output int          num_errors
);

  logic [63:0] expect_q[$];  // one entry per sampled op
  logic [63:0] exp_val;
  int          n_chk = 0;
  int          n_err = 0;

  assign num_checks = n_chk;
  assign num_errors = n_err;

  // expected word from host double arithmetic
  function automatic logic [63:0] ref_result(input logic [63:0] a, input logic [63:0] b,
                                             input logic [1:0] code);
    logic [63:0] a_in;
    logic [63:0] b_in;
    real         ra;
    real         rb;
    real         rr;
    logic [63:0] r;
    a_in = (a[62:52] == '0) ? {a[63], 63'b0} : a;  // denormal in reads as zero
    b_in = (b[62:52] == '0) ? {b[63], 63'b0} : b;
    ra   = $bitstoreal(a_in);
    rb   = $bitstoreal(b_in);
    case (pe_pkg::pe_op_e'(code))
      pe_pkg::op_add: rr = ra + rb;
      pe_pkg::op_sub: rr = ra - rb;
      default:        rr = ra * rb;  // both mul codes
    endcase
    r = $realtobits(rr);
    if (r[62:52] == '0) begin
      r = {r[63], 63'b0};  // denormal results flush to a signed zero
    end
    // cancellation of nonzero operands is +0
    if (!code[1] && (r[62:0] == '0) && ((a_in[62:0] != '0) || (b_in[62:0] != '0))) begin
      r = '0;
    end
    return r;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // delay line and compare on the falling edge
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (!arst_n) begin
      expect_q.delete();
    end else begin
      if (expect_q.size() == pe_pkg::pipe_depth) begin
        exp_val = expect_q.pop_front();  // op sampled pipe_depth edges ago
      end else begin
        exp_val = '0;  // reset contents still draining out of the pipeline
      end
      n_chk++;
      if (out1 !== exp_val) begin
        n_err++;
        $display("ERROR out1 expected %h actual %h at %0t", exp_val, out1, $time);
      end
      expect_q.push_back(ref_result(inp1, inp2, op));  // sampled at next edge
    end
  end

endmodule

/* pe_asserts.sv */
`timescale 1ns/1ps

// port level properties of the PE
module pe_asserts #(
  parameter int dw = 1 + pe_pkg::exp_w_dbl + pe_pkg::man_w_dbl
) (
  input logic          clk,
  input logic          arst_n,
  input logic [dw-1:0] inp1,
  input logic [dw-1:0] inp2,
  input logic [1:0]    op,
  input logic [dw-1:0] out1
);

  int n_fail = 0;  // failures so far, summed into the final count

  reset_clear: assert property (@(posedge clk) !arst_n |-> out1 == '0)
    else begin
      n_fail++;
      $error("out1 is not zero while reset is held");
    end

  no_x_out: assert property (@(posedge clk) disable iff (!arst_n) !$isunknown(out1))
    else begin
      n_fail++;
      $error("out1 carries unknown bits after reset");
    end

  // +0 op +0 stays +0 for add and both multiply codes
  zero_in_zero_out: assert property (@(posedge clk) disable iff (!arst_n)
    (inp1 == '0 && inp2 == '0 && op != pe_pkg::op_sub) |-> ##(pe_pkg::pipe_depth) out1 == '0)
    else begin
      n_fail++;
      $error("zero operands did not give a zero out1 after the pipeline latency");
    end

endmodule

bind pe_typec pe_asserts u_asserts (
  .clk    (clk),
  .arst_n (arst_n),
  .inp1   (inp1),
  .inp2   (inp2),
  .op     (op),
  .out1   (out1)
);

/* tb_pe_typec.sv */
`timescale 1ns/1ps

module tb_pe_typec;

  localparam int exp_w      = pe_pkg::exp_w_dbl;
  localparam int man_w      = pe_pkg::man_w_dbl;
  localparam int dw         = 1 + exp_w + man_w;
  localparam int n_random   = 300;  // back to back random ops
  localparam int wait_limit = 20;   // cycles per wait loop

  localparam logic [dw-1:0] neg_zero = 64'h8000_0000_0000_0000;
  localparam logic [dw-1:0] big      = 64'h6570_0000_0000_0000;  // 2**600
  localparam logic [dw-1:0] neg_big  = 64'hE570_0000_0000_0000;
  localparam logic [dw-1:0] tiny     = 64'h1A70_0000_0000_0000;  // 2**-600
  localparam logic [dw-1:0] neg_tiny = 64'h9A70_0000_0000_0000;

  logic          clk;
  logic          arst_n;
  logic [dw-1:0] inp1;
  logic [dw-1:0] inp2;
  logic [1:0]    op;
  logic [dw-1:0] out1;
  int            seed;
  int            timeouts;
  int            n_checks;
  int            n_errors;
  int            n_assert;

  pe_typec #(.exp_w(exp_w), .man_w(man_w)) u_pe_typec (
    .clk    (clk),
    .arst_n (arst_n),
    .inp1   (inp1),
    .inp2   (inp2),
    .op     (op),
    .out1   (out1)
  );

  pe_checker u_checker (
    .clk        (clk),
    .arst_n     (arst_n),
    .inp1       (inp1),
    .inp2       (inp2),
    .op         (op),
    .out1       (out1),
    .num_checks (n_checks),
    .num_errors (n_errors)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic drive_op(input logic [dw-1:0] a, input logic [dw-1:0] b,
                          input logic [1:0] code);
    @(posedge clk);
    #2;
    inp1 = a;
    inp2 = b;
    op   = code;
  endtask

  // small int times 2**-8..2**8, keeps sums and products exact
  task automatic rand_operand(output logic [dw-1:0] v);
    int  m;
    int  e;
    real r;
    m = $random(seed) % 256;
    e = $random(seed) % 9;
    r = real'(m) * real'(1 << (e + 8)) / 256.0;
    v = $realtobits(r);
  endtask

  // first nonzero word on out1
  task automatic wait_result();
    int n;
    n = 0;
    while (out1 == '0 && n < wait_limit) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (out1 == '0) begin
      timeouts++;
      $display("timeout: out1 stayed zero for %0d cycles after the first operation", wait_limit);
    end
  endtask

  // let the checker see every op still in flight
  task automatic wait_drain();
    int target;
    int n;
    target = n_checks + pe_pkg::pipe_depth + 1;
    n      = 0;
    while (n_checks < target && n < wait_limit) begin
      @(posedge clk);
      n++;
    end
    if (n_checks < target) begin
      timeouts++;
      $display("timeout: the checker did not compare the last results within %0d cycles",
               wait_limit);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [dw-1:0] a;
    logic [dw-1:0] b;
    seed     = 53526;
    timeouts = 0;
    arst_n   = 1'b0;
    inp1     = '0;
    inp2     = '0;
    op       = 2'd0;
    repeat (4) @(posedge clk);
    #2;
    arst_n = 1'b1;

    // idle then one add, checker holds the exact latency
    repeat (3) drive_op('0, '0, pe_pkg::op_add);
    drive_op($realtobits(1.5), $realtobits(2.5), pe_pkg::op_add);
    drive_op('0, '0, pe_pkg::op_add);
    wait_result();

    // bit 1 alone selects the multiply
    drive_op($realtobits(3.0), $realtobits(-5.0), pe_pkg::op_mul);
    drive_op($realtobits(3.0), $realtobits(-5.0), pe_pkg::op_mul_alt);
    drive_op($realtobits(-0.75), $realtobits(8.0), pe_pkg::op_mul_alt);

    // zero rules
    drive_op($realtobits(6.25), $realtobits(6.25), pe_pkg::op_sub);
    drive_op($realtobits(-6.25), $realtobits(6.25), pe_pkg::op_add);
    drive_op('0, $realtobits(-9.5), pe_pkg::op_add);
    drive_op($realtobits(12.0), '0, pe_pkg::op_add);
    drive_op(neg_zero, $realtobits(7.0), pe_pkg::op_mul);
    drive_op($realtobits(-3.0), '0, pe_pkg::op_mul);
    drive_op(neg_zero, $realtobits(-2.0), pe_pkg::op_mul);
    drive_op(neg_zero, neg_zero, pe_pkg::op_add);

    // overflow to inf, underflow to signed zero
    drive_op(big, big, pe_pkg::op_mul);
    drive_op(neg_big, big, pe_pkg::op_mul);
    drive_op(tiny, tiny, pe_pkg::op_mul);
    drive_op(neg_tiny, tiny, pe_pkg::op_mul_alt);

    // random mix, a new op every cycle
    for (int i = 0; i < n_random; i++) begin
      rand_operand(a);
      rand_operand(b);
      drive_op(a, b, 2'($random(seed)));
    end
    wait_drain();

    n_assert = u_pe_typec.u_asserts.n_fail;
    $display("checks %0d, errors %0d, assertion failures %0d, timeouts %0d",
             n_checks, n_errors, n_assert, timeouts);
    if (n_errors == 0 && n_assert == 0 && timeouts == 0 && n_checks > 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* tb.f */
pe_pkg.sv
fp_stage_if.sv
fp_unpack.sv
fp_arith.sv
fp_normalize.sv
pe_typec.sv
pe_checker.sv
pe_asserts.sv
tb_pe_typec.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, and pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_pe_typec \
  -o sim_pe_typec \
  && ./obj_dir/sim_pe_typec +verilator+error+limit+1000 | tee /dev/stderr \
  | grep -q -F '** PASS **' \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
